/* verif/kbd_input.txt */
# columns in hex: frame byte, bad parity flag, then the expected key code,
# ASCII, press count and press level after the frame
1C 0 1C 61 01 1
1C 0 1C 61 01 1
F0 0 1C 61 01 1
1C 0 1C 61 01 0
32 1 1C 61 01 0
32 0 32 62 02 1
21 0 21 63 03 1
F0 0 21 63 03 1
32 0 21 63 03 1
F0 0 21 63 03 1
21 0 21 63 03 0
23 0 23 64 04 1
24 0 24 65 05 1
2B 0 2B 66 06 1
34 0 34 67 07 1
33 0 33 68 08 1
43 0 43 69 09 1
3B 0 3B 6A 0A 1
42 0 42 6B 0B 1
4B 0 4B 6C 0C 1
3A 0 3A 6D 0D 1
31 0 31 6E 0E 1
44 0 44 6F 0F 1
4D 0 4D 70 10 1
F0 1 4D 70 10 1
45 0 45 30 11 1
29 0 29 20 12 1
5A 0 5A 0D 13 1
5A 0 5A 0D 13 1
F0 0 5A 0D 13 1
5A 0 5A 0D 13 0

/* list.f */
design/kbd_pkg.sv
design/ps2_rx.sv
design/kbd_ctrl.sv
design/key2ascii.sv
design/hex7seg.sv
design/top.sv
verif/tb_clk_gen.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -o Vtb_top -f list.f

./obj_dir/Vtb_top | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation finished without failure"

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    import kbd_pkg::*;

    localparam int PS2_HALF_CYCLES = 20;
    localparam int SETTLE_CYCLES   = 10;
    localparam int CYCLES_PER_STEP = 500;

    // one line of the data file.
    typedef struct packed {
        scan_code_t   data;
        logic         corrupt;
        scan_code_t   code;
        ascii_t       ascii;
        press_count_t count;
        logic         press;
    } step_t;

    logic  clk;
    logic  arst_n;
    logic  ps2_clk;
    logic  ps2_data;
    seg_t  key_lo_seg;
    seg_t  key_hi_seg;
    seg_t  seg2;
    seg_t  ascii_lo_seg;
    seg_t  ascii_hi_seg;
    seg_t  seg5;
    seg_t  count_lo_seg;
    seg_t  count_hi_seg;
    logic  is_press;

    step_t steps[$];
    int    cycle_cnt   = 0;
    int    cycle_limit = 0;

    tb_clk_gen #(
        .HALF_PERIOD_NS (2),
        .RESET_CYCLES   (8)
    ) clk_gen_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    top #(
        .SYNC_STAGES (2)
    ) top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_lo_seg   (key_lo_seg),
        .key_hi_seg   (key_hi_seg),
        .seg2         (seg2),
        .ascii_lo_seg (ascii_lo_seg),
        .ascii_hi_seg (ascii_hi_seg),
        .seg5         (seg5),
        .count_lo_seg (count_lo_seg),
        .count_hi_seg (count_hi_seg),
        .is_press     (is_press)
    );

    // common-anode patterns, dot off.
    function automatic seg_t hex_seg(input logic [3:0] n);
        case (n)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected)
        else begin
            $display("[FAIL] t=%0t %s expected %02h actual %02h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_outputs(input step_t exp);
        seg_t e_key_lo;
        seg_t e_key_hi;
        seg_t e_ascii_lo;
        seg_t e_ascii_hi;
        seg_t e_count_lo;
        seg_t e_count_hi;
        e_key_lo   = '1;
        e_key_hi   = '1;
        e_ascii_lo = '1;
        e_ascii_hi = '1;
        e_count_lo = '1;
        e_count_hi = '1;
        if (exp.press) begin
            e_key_lo   = hex_seg(exp.code[3:0]);
            e_key_hi   = hex_seg(exp.code[7:4]);
            e_ascii_lo = hex_seg(exp.ascii[3:0]);
            e_ascii_hi = hex_seg(exp.ascii[7:4]);
            e_count_lo = hex_seg(exp.count[3:0]);
            e_count_hi = hex_seg(exp.count[7:4]);
        end
        check_value("is_press", {7'd0, exp.press}, {7'd0, is_press});
        check_value("key_lo_seg", e_key_lo, key_lo_seg);
        check_value("key_hi_seg", e_key_hi, key_hi_seg);
        check_value("seg2", 8'hFF, seg2);
        check_value("ascii_lo_seg", e_ascii_lo, ascii_lo_seg);
        check_value("ascii_hi_seg", e_ascii_hi, ascii_hi_seg);
        check_value("seg5", 8'hFF, seg5);
        check_value("count_lo_seg", e_count_lo, count_lo_seg);
        check_value("count_hi_seg", e_count_hi, count_hi_seg);
    endtask

    // the device drives clock low for half a period, data is set well before.
    task automatic send_bit(input logic b);
        @(posedge clk);
        ps2_data <= b;
        repeat (PS2_HALF_CYCLES) @(posedge clk);
        ps2_clk <= 1'b0;
        repeat (PS2_HALF_CYCLES) @(posedge clk);
        ps2_clk <= 1'b1;
    endtask

    task automatic send_frame(input scan_code_t value, input logic corrupt);
        logic parity_bit;
        parity_bit = (~^value) ^ corrupt;
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(value[i]);
        end
        send_bit(parity_bit);
        send_bit(1'b1);
    endtask

    task automatic read_steps();
        int         fd;
        int         n;
        string      line;
        logic [7:0] v_data;
        logic [7:0] v_corrupt;
        logic [7:0] v_code;
        logic [7:0] v_ascii;
        logic [7:0] v_count;
        logic [7:0] v_press;
        fd = $fopen("verif/kbd_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/kbd_input.txt for reading");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h",
                            v_data, v_corrupt, v_code, v_ascii, v_count, v_press);
                if (n == 6) begin
                    steps.push_back({v_data, v_corrupt[0], v_code, v_ascii, v_count, v_press[0]});
                end else if (n > 0) begin
                    $display("malformed line in the stimulus file: %s", line);
                    abort_run();
                end
            end
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            $display("the stimulus file holds no steps");
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
            abort_run();
        end
    end

    initial begin
        ps2_clk  <= 1'b1;
        ps2_data <= 1'b1;
        read_steps();
        cycle_limit = steps.size() * CYCLES_PER_STEP + 100;
        @(posedge arst_n);
        repeat (SETTLE_CYCLES) @(posedge clk);
        @(negedge clk);
        check_outputs('0);
        foreach (steps[i]) begin
            $display("step %0d: byte %02h%s%s", i, steps[i].data,
                     (steps[i].data == BREAK_CODE) ? " (break prefix)" : "",
                     steps[i].corrupt ? " with bad parity" : "");
            send_frame(steps[i].data, steps[i].corrupt);
            repeat (SETTLE_CYCLES) @(posedge clk);
            @(negedge clk);
            check_outputs(steps[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // reset is released on a rising edge after the hold time.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

/* design/top.sv */
`timescale 1ns/1ps

module top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          ps2_clk,
    input  logic          ps2_data,
    output kbd_pkg::seg_t key_lo_seg,
    output kbd_pkg::seg_t key_hi_seg,
    output kbd_pkg::seg_t seg2,
    output kbd_pkg::seg_t ascii_lo_seg,
    output kbd_pkg::seg_t ascii_hi_seg,
    output kbd_pkg::seg_t seg5,
    output kbd_pkg::seg_t count_lo_seg,
    output kbd_pkg::seg_t count_hi_seg,
    output logic          is_press
);

    import kbd_pkg::*;

    key_state_t       key_state;
    ascii_t           ascii;
    logic [5:0][3:0]  nibble;
    seg_t [5:0]       digit_seg;

    kbd_ctrl #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_kbd_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .key_state (key_state)
    );

    key2ascii u_key2ascii (
        .data  (key_state.code),
        .ascii (ascii)
    );

    // digit 0 is the low key nibble, digit 5 the high count nibble.
    assign nibble = {key_state.count, ascii, key_state.code};

    for (genvar i = 0; i < 6; i++) begin : g_digit
        hex7seg u_hex7seg (
            .b (nibble[i]),
            .h (digit_seg[i])
        );
    end

    assign is_press = key_state.pressed;

    assign {count_hi_seg, count_lo_seg, ascii_hi_seg, ascii_lo_seg, key_hi_seg, key_lo_seg} =
        key_state.pressed ? digit_seg : '1;

    assign seg2 = '1;
    assign seg5 = '1;

endmodule

/* design/hex7seg.sv */
`timescale 1ns/1ps

module hex7seg (
    input  logic [3:0]     b,
    output kbd_pkg::seg_t  h
);

    // segments lit, ordered g..a, before the active-low inversion.
    logic [6:0] lit;

    always_comb begin
        case (b)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
    end

    assign h = {1'b1, ~lit};

endmodule

/* design/key2ascii.sv */
`timescale 1ns/1ps

module key2ascii (
    input  kbd_pkg::scan_code_t data,
    output kbd_pkg::ascii_t     ascii
);

    // set 2 codes are not ordered like the characters, hence a full table.
    always_comb begin
        case (data)
            // letters
            8'h1C: ascii = 8'h61;
            8'h32: ascii = 8'h62;
            8'h21: ascii = 8'h63;
            8'h23: ascii = 8'h64;
            8'h24: ascii = 8'h65;
            8'h2B: ascii = 8'h66;
            8'h34: ascii = 8'h67;
            8'h33: ascii = 8'h68;
            8'h43: ascii = 8'h69;
            8'h3B: ascii = 8'h6A;
            8'h42: ascii = 8'h6B;
            8'h4B: ascii = 8'h6C;
            8'h3A: ascii = 8'h6D;
            8'h31: ascii = 8'h6E;
            8'h44: ascii = 8'h6F;
            8'h4D: ascii = 8'h70;
            8'h15: ascii = 8'h71;
            8'h2D: ascii = 8'h72;
            8'h1B: ascii = 8'h73;
            8'h2C: ascii = 8'h74;
            8'h3C: ascii = 8'h75;
            8'h2A: ascii = 8'h76;
            8'h1D: ascii = 8'h77;
            8'h22: ascii = 8'h78;
            8'h35: ascii = 8'h79;
            8'h1A: ascii = 8'h7A;

            // digits on the main row
            8'h45: ascii = 8'h30;
            8'h16: ascii = 8'h31;
            8'h1E: ascii = 8'h32;
            8'h26: ascii = 8'h33;
            8'h25: ascii = 8'h34;
            8'h2E: ascii = 8'h35;
            8'h36: ascii = 8'h36;
            8'h3D: ascii = 8'h37;
            8'h3E: ascii = 8'h38;
            8'h46: ascii = 8'h39;

            // space and enter, enter gives a carriage return
            8'h29: ascii = 8'h20;
            8'h5A: ascii = 8'h0D;

            default: ascii = 8'h00;
        endcase
    end

endmodule

/* design/kbd_ctrl.sv */
`timescale 1ns/1ps

module kbd_ctrl #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output kbd_pkg::key_state_t key_state
);

    import kbd_pkg::*;

    // the prefix of the extended codes is dropped on its own.
    localparam scan_code_t EXT_CODE = 8'hE0;

    logic       byte_valid;
    scan_code_t rx_byte;
    logic       break_flag;
    logic       is_repeat;

    ps2_rx #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_ps2_rx (
        .clk        (clk),
        .arst_n     (arst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    // a held key keeps sending its make code at the typematic rate.
    assign is_repeat = key_state.pressed && (rx_byte == key_state.code);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_state  <= '0;
            break_flag <= 1'b0;
        end else if (byte_valid) begin
            if (rx_byte == BREAK_CODE) begin
                break_flag <= 1'b1;
            end else if (rx_byte == EXT_CODE) begin
                break_flag <= break_flag;
            end else if (break_flag) begin
                // release of some other key leaves the held one alone.
                break_flag <= 1'b0;
                if (rx_byte == key_state.code) begin
                    key_state.pressed <= 1'b0;
                end
            end else begin
                key_state.code    <= rx_byte;
                key_state.pressed <= 1'b1;
                if (!is_repeat) begin
                    key_state.count <= key_state.count + 8'd1;
                end
            end
        end
    end

    // the count only moves on a make code, which always leaves the key held.
    a_count_on_press: assert property (
        @(posedge clk) disable iff (!arst_n)
        (key_state.count != $past(key_state.count)) |-> key_state.pressed
    );

endmodule

/* design/ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output logic                byte_valid,
    output kbd_pkg::scan_code_t rx_byte
);

    import kbd_pkg::*;

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] data_sync;
    logic                   clk_prev;
    logic                   clk_fall;
    logic                   data_s;
    rx_state_t              state;
    logic [2:0]             bit_cnt;
    logic                   parity;

    // both lines idle high, so the synchronizers reset to ones and no
    // false falling edge is seen when reset is released.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_sync[SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[SYNC_STAGES-1];
    assign data_s   = data_sync[SYNC_STAGES-1];

    // the keyboard changes data on the rising edge, so it is stable
    // when the falling edge is seen.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            bit_cnt    <= 3'd0;
            parity     <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    IDLE: begin
                        bit_cnt <= 3'd0;
                        parity  <= 1'b0;
                        if (!data_s) begin
                            state <= DATA;
                        end
                    end
                    DATA: begin
                        parity  <= parity ^ data_s;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        // high here means the nine bits hold an odd number of ones.
                        parity <= parity ^ data_s;
                        state  <= STOP;
                    end
                    STOP: begin
                        byte_valid <= parity & data_s;
                        state      <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall && state == DATA) begin
            rx_byte <= {data_s, rx_byte[7:1]};
        end
    end

    // a frame is eleven PS/2 clocks long, so two strobes can never touch.
    a_strobe_single: assert property (
        @(posedge clk) disable iff (!arst_n) byte_valid |=> !byte_valid
    );

endmodule

/* design/kbd_pkg.sv */
package kbd_pkg;

    // one byte as it arrives from the keyboard, scan code set 2.
    typedef logic [7:0] scan_code_t;

    // lower-case ASCII character, 0 when the key has no mapping.
    typedef logic [7:0] ascii_t;

    // number of new key presses, wraps at 256.
    typedef logic [7:0] press_count_t;

    // active-low segment pattern, bit 7 is the dot and bits 6..0 are g..a.
    typedef logic [7:0] seg_t;

    // what the keyboard controller knows about the keyboard.
    typedef struct packed {
        scan_code_t   code;
        logic         pressed;
        press_count_t count;
    } key_state_t;

    // PS/2 receive FSM.
    // IDLE waits for the start bit, DATA takes eight bits LSB first,
    // PARITY takes the odd parity bit and STOP checks the stop bit.
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } rx_state_t;

    // prefix sent by the keyboard ahead of the code of a released key.
    localparam scan_code_t BREAK_CODE = 8'hF0;

endpackage
